// File: common/rv32_consts.svh
// RV32 back end constants

`ifndef RV32_CONSTS_SVH
`define RV32_CONSTS_SVH

`define RV_XLEN        32
`define RV_NOP_INSTR   32'h0000_0013

// Machine CSR ids
`define CSR_MSTATUS    12'h300
`define CSR_MIE        12'h304
`define CSR_MTVEC      12'h305
`define CSR_MEPC       12'h341
`define CSR_MCAUSE     12'h342
`define CSR_MINSTRET   12'hB02

// Address map and sizes
`define MTIMECMP_ADDR  32'h0200_4000
`define RAM_WORDS      256

// Reset values and causes
`define MTVEC_RESET    32'h0000_0100
`define MCAUSE_MTI     32'h8000_0007

`endif

// File: common/rv32_types.sv
// RV32 back end shared types

`include "rv32_consts.svh"

package rv32_types;

    typedef logic [`RV_XLEN-1:0] rv32_word;

    typedef enum logic [1:0] {
        MEM_NOP   = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // Per-instruction control bits carried down the pipe
    typedef struct packed {
        mem_op_e mem_op;
        logic    csr_wb;
        logic    is_mret;
        logic    is_bubble;
        logic    reg_wb;
    } ctrl_t;

    // Word 0 is store data or ALU result, word 1 is address or CSR value
    typedef struct packed {
        rv32_word       pc;
        rv32_word       instr;
        ctrl_t          ctrl;
        rv32_word [1:0] data_result;
    } exec_mem_buffer_t;

    // Same layout, word 0 carries load data for loads
    typedef struct packed {
        rv32_word       pc;
        rv32_word       instr;
        ctrl_t          ctrl;
        rv32_word [1:0] data_result;
    } mem_wb_buffer_t;

    typedef struct packed {
        rv32_word addr;
        mem_op_e  op;
        rv32_word data;
    } memory_request_t;

    typedef struct packed {
        logic [11:0] id;
        rv32_word    value;
        logic        write;
    } csr_write_request_t;

    typedef struct packed {
        logic mie;
        logic mpie;
    } mstatus_t;

    typedef struct packed {
        logic mtie;
    } mie_t;

    typedef struct packed {
        logic     do_interrupt;
        logic     is_mret;
        rv32_word from;
    } interrupt_request_t;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        rv32_word adr;
        rv32_word dat;
    } wb_m2s_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic     ack;
        rv32_word dat;
    } wb_s2m_t;

    function automatic ctrl_t create_bubble_ctrl();
        ctrl_t c;
        c.mem_op    = MEM_NOP;
        c.csr_wb    = 1'b0;
        c.is_mret   = 1'b0;
        c.is_bubble = 1'b1;
        c.reg_wb    = 1'b0;
        return c;
    endfunction

endpackage

// File: mem_stage/rv32_mem_stage.sv
// RV32 memory stage
// Consolidation point and mem/wb buffer

`timescale 1ns/1ps
`include "rv32_consts.svh"

module rv32_mem_stage (
    input  logic                          clk,
    input  logic                          resetn,
    input  rv32_types::rv32_word          mepc,
    input  rv32_types::mstatus_t          mstatus,
    input  rv32_types::mie_t              mie,
    input  logic                          mtip,
    input  rv32_types::exec_mem_buffer_t  exec_mem_buff,
    input  rv32_types::rv32_word          load_data,
    input  logic                          request_done,
    output rv32_types::mem_wb_buffer_t    mem_wb_buff,
    output logic                          stall,
    output rv32_types::interrupt_request_t interrupt_request,
    output rv32_types::memory_request_t   data_request,
    output rv32_types::csr_write_request_t csr_write_request,
    output logic                          instr_retired
);
    import rv32_types::*;

    mem_wb_buffer_t next_buff;
    logic           irq_pending;
    logic           take_trap;
    logic           is_bubble;

    always_comb begin
        is_bubble   = exec_mem_buff.ctrl.is_bubble;
        irq_pending = mstatus.mie & mie.mtie & mtip;

        // CSR writes commit here
        csr_write_request.id    = exec_mem_buff.instr[31:20];
        csr_write_request.value = exec_mem_buff.data_result[1];
        csr_write_request.write = exec_mem_buff.ctrl.csr_wb & ~is_bubble;

        data_request.addr = exec_mem_buff.data_result[1];
        data_request.op   = is_bubble ? MEM_NOP : exec_mem_buff.ctrl.mem_op;
        data_request.data = exec_mem_buff.data_result[0];

        interrupt_request.is_mret = exec_mem_buff.ctrl.is_mret & ~is_bubble;
        interrupt_request.from    = interrupt_request.is_mret ? mepc : exec_mem_buff.pc;
        interrupt_request.do_interrupt = 1'b0;

        // mret or an enabled timer interrupt takes the pipeline
        if (!is_bubble && (interrupt_request.is_mret || irq_pending)) begin
            data_request.op                = MEM_NOP;
            csr_write_request.write        = 1'b0;
            interrupt_request.do_interrupt = 1'b1;
        end

        take_trap = interrupt_request.do_interrupt & ~interrupt_request.is_mret;

        // Hold until the bus acknowledges
        stall = (data_request.op != MEM_NOP) & ~request_done;

        next_buff = exec_mem_buff;
        if (exec_mem_buff.ctrl.mem_op == MEM_LOAD) begin
            next_buff.data_result[0] = load_data;
        end

        instr_retired = ~is_bubble & ~stall & ~take_trap;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_wb_buff.pc    <= '0;
            mem_wb_buff.instr <= `RV_NOP_INSTR;
            mem_wb_buff.ctrl  <= create_bubble_ctrl();
        end else if (take_trap) begin
            // Flush the interrupted instruction
            mem_wb_buff.ctrl <= create_bubble_ctrl();
        end else if (stall) begin
            // Bubble downstream, data fields kept for bypass
            mem_wb_buff.ctrl.is_bubble <= 1'b1;
        end else begin
            mem_wb_buff <= next_buff;
        end
    end

endmodule

// File: mem_stage/rv32_wb_data_master.sv
// Wishbone classic data master

`timescale 1ns/1ps

module rv32_wb_data_master (
    input  rv32_types::memory_request_t data_request,
    output rv32_types::wb_m2s_t         wb_out,
    input  rv32_types::wb_s2m_t         wb_in,
    output logic                        request_done,
    output rv32_types::rv32_word        load_data
);
    import rv32_types::*;

    logic active;

    always_comb begin
        active = (data_request.op == MEM_LOAD) || (data_request.op == MEM_STORE);

        // cyc and stb rise together and hold until ack
        wb_out.cyc = active;
        wb_out.stb = active;
        wb_out.we  = (data_request.op == MEM_STORE);

        // Word accesses only
        wb_out.adr = {data_request.addr[31:2], 2'b00};
        wb_out.dat = data_request.data;

        request_done = wb_in.ack;
        load_data    = wb_in.dat;
    end

endmodule

// File: logic/rv32_csr_file.sv
// Machine-mode CSR file

`timescale 1ns/1ps
`include "rv32_consts.svh"

module rv32_csr_file (
    input  logic                           clk,
    input  logic                           resetn,
    input  rv32_types::csr_write_request_t csr_write_request,
    input  rv32_types::interrupt_request_t interrupt_request,
    input  logic                           instr_retired,
    input  logic [11:0]                    csr_read_id,
    output rv32_types::rv32_word           csr_read_value,
    output rv32_types::rv32_word           mepc,
    output rv32_types::mstatus_t           mstatus,
    output rv32_types::mie_t               mie,
    output logic                           redirect_valid,
    output rv32_types::rv32_word           redirect_pc
);
    import rv32_types::*;

    rv32_word mtvec;
    rv32_word mcause;
    rv32_word minstret;
    logic     trap_entry;
    logic     wr;

    assign trap_entry = interrupt_request.do_interrupt & ~interrupt_request.is_mret;
    assign wr         = csr_write_request.write;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= `MTVEC_RESET;
            mepc     <= '0;
            mcause   <= '0;
            minstret <= '0;
        end else begin
            if (trap_entry) begin
                mepc         <= interrupt_request.from;
                mcause       <= `MCAUSE_MTI;
                mstatus.mpie <= mstatus.mie;
                mstatus.mie  <= 1'b0;
            end else if (interrupt_request.do_interrupt) begin
                // mret
                mstatus.mie <= mstatus.mpie;
            end else if (wr) begin
                case (csr_write_request.id)
                    `CSR_MSTATUS: begin
                        mstatus.mie  <= csr_write_request.value[3];
                        mstatus.mpie <= csr_write_request.value[7];
                    end
                    `CSR_MIE:    mie.mtie <= csr_write_request.value[7];
                    `CSR_MTVEC:  mtvec    <= {csr_write_request.value[31:2], 2'b00};
                    `CSR_MEPC:   mepc     <= {csr_write_request.value[31:2], 2'b00};
                    `CSR_MCAUSE: mcause   <= csr_write_request.value;
                    default: ;
                endcase
            end

            if (wr && csr_write_request.id == `CSR_MINSTRET) begin
                minstret <= csr_write_request.value;
            end else if (instr_retired) begin
                minstret <= minstret + 32'd1;
            end
        end
    end

    always_comb begin
        case (csr_read_id)
            `CSR_MSTATUS:  csr_read_value = {24'd0, mstatus.mpie, 3'd0, mstatus.mie, 3'd0};
            `CSR_MIE:      csr_read_value = {24'd0, mie.mtie, 7'd0};
            `CSR_MTVEC:    csr_read_value = mtvec;
            `CSR_MEPC:     csr_read_value = mepc;
            `CSR_MCAUSE:   csr_read_value = mcause;
            `CSR_MINSTRET: csr_read_value = minstret;
            default:       csr_read_value = '0;
        endcase
    end

    // Redirect in the same cycle the stage decides
    assign redirect_valid = interrupt_request.do_interrupt;
    assign redirect_pc    = interrupt_request.is_mret ? mepc : mtvec;

endmodule

// File: logic/rv32_mtimer.sv
// Machine timer with compare register

`timescale 1ns/1ps

module rv32_mtimer (
    input  logic                clk,
    input  logic                resetn,
    input  rv32_types::wb_m2s_t wb_in,
    output rv32_types::wb_s2m_t wb_out,
    output logic                mtip
);
    import rv32_types::*;

    rv32_word mtime;
    rv32_word mtimecmp;
    rv32_word rd_dat;
    logic     ack;
    logic     sel;

    assign sel = wb_in.cyc & wb_in.stb;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mtime    <= '0;
            mtimecmp <= '1;
            ack      <= 1'b0;
        end else begin
            mtime <= mtime + 32'd1;
            // One ack per strobe
            ack   <= sel & ~ack;
            if (sel && ack && wb_in.we) begin
                mtimecmp <= wb_in.dat;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel && !ack) begin
            rd_dat <= mtimecmp;
        end
    end

    assign wb_out.ack = ack;
    assign wb_out.dat = rd_dat;
    assign mtip       = (mtime >= mtimecmp);

endmodule

// File: logic/rv32_wb_decode.sv
// Wishbone data bus decoder

`timescale 1ns/1ps
`include "rv32_consts.svh"

module rv32_wb_decode (
    input  rv32_types::wb_m2s_t wb_in,
    output rv32_types::wb_s2m_t wb_resp,
    output rv32_types::wb_m2s_t ram_req,
    output rv32_types::wb_m2s_t timer_req,
    input  rv32_types::wb_s2m_t ram_resp,
    input  rv32_types::wb_s2m_t timer_resp
);
    import rv32_types::*;

    logic timer_sel;

    always_comb begin
        timer_sel = (wb_in.adr == `MTIMECMP_ADDR);

        // Only the selected slave sees the strobe
        ram_req       = wb_in;
        ram_req.cyc   = wb_in.cyc & ~timer_sel;
        ram_req.stb   = wb_in.stb & ~timer_sel;
        timer_req     = wb_in;
        timer_req.cyc = wb_in.cyc & timer_sel;
        timer_req.stb = wb_in.stb & timer_sel;

        wb_resp = timer_sel ? timer_resp : ram_resp;
    end

endmodule

// File: logic/rv32_data_ram.sv
// Word-addressed data RAM slave

`timescale 1ns/1ps
`include "rv32_consts.svh"

module rv32_data_ram (
    input  logic                clk,
    input  logic                resetn,
    input  rv32_types::wb_m2s_t wb_in,
    output rv32_types::wb_s2m_t wb_out
);
    import rv32_types::*;

    localparam int IDX_W = $clog2(`RAM_WORDS);

    rv32_word             mem [`RAM_WORDS];
    rv32_word             rd_dat;
    logic [IDX_W-1:0]     idx;
    logic                 ack;
    logic                 sel;

    // Upper address bits wrap around
    assign idx = wb_in.adr[IDX_W+1:2];
    assign sel = wb_in.cyc & wb_in.stb;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ack <= 1'b0;
            for (int i = 0; i < `RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            ack <= sel & ~ack;
            // Store lands in the acknowledged cycle
            if (sel && ack && wb_in.we) begin
                mem[idx] <= wb_in.dat;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sel && !ack) begin
            rd_dat <= mem[idx];
        end
    end

    assign wb_out.ack = ack;
    assign wb_out.dat = rd_dat;

endmodule

// File: logic/rv32_backend_top.sv
// RV32 pipeline back end top

`timescale 1ns/1ps

module rv32_backend_top (
    input  logic                         clk,
    input  logic                         resetn,
    input  rv32_types::exec_mem_buffer_t exec_mem_buff,
    input  logic [11:0]                  csr_read_id,
    output rv32_types::mem_wb_buffer_t   mem_wb_buff,
    output logic                         stall,
    output rv32_types::rv32_word         csr_read_value,
    output logic                         redirect_valid,
    output rv32_types::rv32_word         redirect_pc
);
    import rv32_types::*;

    memory_request_t    data_request;
    rv32_word           load_data;
    logic               request_done;
    csr_write_request_t csr_write_request;
    interrupt_request_t interrupt_request;
    logic               instr_retired;
    rv32_word           mepc;
    mstatus_t           mstatus;
    mie_t               mie;
    logic               mtip;
    wb_m2s_t            bus_req;
    wb_s2m_t            bus_resp;
    wb_m2s_t            ram_req;
    wb_s2m_t            ram_resp;
    wb_m2s_t            timer_req;
    wb_s2m_t            timer_resp;

    rv32_mem_stage u_mem_stage (
        .clk               (clk),
        .resetn            (resetn),
        .mepc              (mepc),
        .mstatus           (mstatus),
        .mie               (mie),
        .mtip              (mtip),
        .exec_mem_buff     (exec_mem_buff),
        .load_data         (load_data),
        .request_done      (request_done),
        .mem_wb_buff       (mem_wb_buff),
        .stall             (stall),
        .interrupt_request (interrupt_request),
        .data_request      (data_request),
        .csr_write_request (csr_write_request),
        .instr_retired     (instr_retired)
    );

    rv32_wb_data_master u_master (
        .data_request (data_request),
        .wb_out       (bus_req),
        .wb_in        (bus_resp),
        .request_done (request_done),
        .load_data    (load_data)
    );

    rv32_wb_decode u_decode (
        .wb_in      (bus_req),
        .wb_resp    (bus_resp),
        .ram_req    (ram_req),
        .timer_req  (timer_req),
        .ram_resp   (ram_resp),
        .timer_resp (timer_resp)
    );

    rv32_data_ram u_ram (
        .clk    (clk),
        .resetn (resetn),
        .wb_in  (ram_req),
        .wb_out (ram_resp)
    );

    rv32_mtimer u_timer (
        .clk    (clk),
        .resetn (resetn),
        .wb_in  (timer_req),
        .wb_out (timer_resp),
        .mtip   (mtip)
    );

    rv32_csr_file u_csr (
        .clk               (clk),
        .resetn            (resetn),
        .csr_write_request (csr_write_request),
        .interrupt_request (interrupt_request),
        .instr_retired     (instr_retired),
        .csr_read_id       (csr_read_id),
        .csr_read_value    (csr_read_value),
        .mepc              (mepc),
        .mstatus           (mstatus),
        .mie               (mie),
        .redirect_valid    (redirect_valid),
        .redirect_pc       (redirect_pc)
    );

endmodule

// File: verification/rv32_backend_tb.sv
// RV32 back end testbench

`timescale 1ns/1ps
`include "rv32_consts.svh"

module rv32_backend_tb;
    import rv32_types::*;

    localparam int NUM_RANDOM  = 400;
    localparam int NUM_TESTS   = NUM_RANDOM + 24;
    localparam int WATCHDOG_NS = (NUM_TESTS * 3 + 16) * 100;

    logic             clk;
    logic             resetn;
    exec_mem_buffer_t exec_mem_buff;
    logic [11:0]      csr_read_id;
    mem_wb_buffer_t   mem_wb_buff;
    logic             stall;
    rv32_word         csr_read_value;
    logic             redirect_valid;
    rv32_word         redirect_pc;

    // Reference model state
    rv32_word    ram_model [`RAM_WORDS];
    rv32_word    m_mtimecmp;
    rv32_word    m_mepc;
    rv32_word    m_mtvec;
    rv32_word    m_mcause;
    logic        m_mie;
    logic        m_mpie;
    logic        m_mtie;
    int          m_retired;
    logic [31:0] lfsr_state;
    rv32_word    pc_count;
    int          read_sel;
    int          errors;
    int          checks;

    rv32_backend_top uut (
        .clk            (clk),
        .resetn         (resetn),
        .exec_mem_buff  (exec_mem_buff),
        .csr_read_id    (csr_read_id),
        .mem_wb_buff    (mem_wb_buff),
        .stall          (stall),
        .csr_read_value (csr_read_value),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

    // Galois LFSR stepped once per bit
    function automatic rv32_word rand_bits(input int n);
        rv32_word r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic rv32_word expected_csr(input logic [11:0] id);
        case (id)
            `CSR_MSTATUS: return {24'd0, m_mpie, 3'd0, m_mie, 3'd0};
            `CSR_MIE:     return {24'd0, m_mtie, 7'd0};
            `CSR_MTVEC:   return m_mtvec;
            `CSR_MEPC:    return m_mepc;
            `CSR_MCAUSE:  return m_mcause;
            default:      return 32'd0;
        endcase
    endfunction

    // Class 0 bubble, 1 ALU, 2 load, 3 store, 4 CSR write, 5 mret
    function automatic exec_mem_buffer_t make_instr(input int cls, input rv32_word addr,
                                                    input rv32_word data, input logic [11:0] id);
        exec_mem_buffer_t b;
        b.pc             = pc_count;
        b.instr          = (cls == 5) ? 32'h3020_0073 : {id, 20'h0_2073};
        b.ctrl           = create_bubble_ctrl();
        b.ctrl.is_bubble = (cls == 0);
        b.ctrl.reg_wb    = (cls == 1) || (cls == 2);
        b.ctrl.mem_op    = (cls == 2) ? MEM_LOAD : ((cls == 3) ? MEM_STORE : MEM_NOP);
        b.ctrl.csr_wb    = (cls == 4);
        b.ctrl.is_mret   = (cls == 5);
        b.data_result[0] = data;
        b.data_result[1] = (cls == 4) ? data : addr;
        return b;
    endfunction

    task automatic check_value(input string name, input rv32_word expected, input rv32_word actual);
        checks++;
        if (expected !== actual) begin
            $display("FAILED %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (expected !== actual) begin
            $display("FAILED %s expected %b actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic read_csr(input logic [11:0] id, input string name);
        @(posedge clk);
        csr_read_id <= id;
        @(negedge clk);
        check_value(name, expected_csr(id), csr_read_value);
    endtask

    task automatic execute(input exec_mem_buffer_t ib, input logic expect_trap, input string name);
        logic        bub;
        logic        mret;
        logic        trap;
        logic        mem;
        logic        is_timer;
        int          stall_cycles;
        rv32_word    exp_load;
        logic [11:0] rd_id;
        logic [11:0] ids [4];
        ids[0] = `CSR_MSTATUS;
        ids[1] = `CSR_MIE;
        ids[2] = `CSR_MTVEC;
        ids[3] = `CSR_MEPC;
        bub  = ib.ctrl.is_bubble;
        mret = !bub && ib.ctrl.is_mret;
        trap = !bub && !mret && expect_trap;
        mem  = !bub && !mret && !trap && (ib.ctrl.mem_op != MEM_NOP);
        is_timer = (ib.data_result[1] == `MTIMECMP_ADDR);
        exp_load = '0;
        stall_cycles = 0;
        @(posedge clk);
        exec_mem_buff <= ib;
        @(negedge clk);
        while (stall) begin
            stall_cycles++;
            @(negedge clk);
        end
        check_value({name, " stall cycles"}, mem ? 1 : 0, stall_cycles);
        check_flag({name, " redirect valid"}, mret || trap, redirect_valid);
        if (mret || trap) begin
            check_value({name, " redirect pc"}, mret ? m_mepc : m_mtvec, redirect_pc);
        end
        // Model update
        if (trap) begin
            m_mepc   = ib.pc;
            m_mcause = `MCAUSE_MTI;
            m_mpie   = m_mie;
            m_mie    = 1'b0;
        end else if (mret) begin
            m_mie = m_mpie;
        end else if (!bub) begin
            if (ib.ctrl.csr_wb) begin
                case (ib.instr[31:20])
                    `CSR_MSTATUS: begin
                        m_mie  = ib.data_result[1][3];
                        m_mpie = ib.data_result[1][7];
                    end
                    `CSR_MIE:   m_mtie  = ib.data_result[1][7];
                    `CSR_MTVEC: m_mtvec = {ib.data_result[1][31:2], 2'b00};
                    `CSR_MEPC:  m_mepc  = {ib.data_result[1][31:2], 2'b00};
                    default: ;
                endcase
            end
            if (ib.ctrl.mem_op == MEM_LOAD) begin
                exp_load = is_timer ? m_mtimecmp : ram_model[ib.data_result[1][9:2]];
            end else if (ib.ctrl.mem_op == MEM_STORE) begin
                if (is_timer) begin
                    m_mtimecmp = ib.data_result[0];
                end else begin
                    ram_model[ib.data_result[1][9:2]] = ib.data_result[0];
                end
            end
        end
        if (!bub && !trap) begin
            m_retired++;
        end
        rd_id = ids[read_sel % 4];
        read_sel++;
        @(posedge clk);
        exec_mem_buff <= make_instr(0, '0, '0, '0);
        csr_read_id   <= rd_id;
        @(negedge clk);
        check_flag({name, " bubble flag"}, bub || trap, mem_wb_buff.ctrl.is_bubble);
        if (!bub && !trap) begin
            check_value({name, " pc"}, ib.pc, mem_wb_buff.pc);
            if (ib.ctrl.mem_op == MEM_LOAD) begin
                check_value({name, " load data"}, exp_load, mem_wb_buff.data_result[0]);
            end else begin
                check_value({name, " result"}, ib.data_result[0], mem_wb_buff.data_result[0]);
            end
        end
        check_value({name, " csr readback"}, expected_csr(rd_id), csr_read_value);
        pc_count = pc_count + 4;
    endtask

    initial begin
        int       cls;
        rv32_word addr;
        logic [11:0] id;
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'h4027;
        pc_count   = 32'h0000_1000;
        read_sel   = 0;
        m_mtimecmp = '1;
        m_mepc     = '0;
        m_mtvec    = `MTVEC_RESET;
        m_mcause   = '0;
        m_mie      = 1'b0;
        m_mpie     = 1'b0;
        m_mtie     = 1'b0;
        m_retired  = 0;
        for (int i = 0; i < `RAM_WORDS; i++) begin
            ram_model[i] = '0;
        end
        resetn        <= 1'b0;
        csr_read_id   <= `CSR_MSTATUS;
        exec_mem_buff <= make_instr(0, '0, '0, '0);
        repeat (16) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_flag("reset stall", 1'b0, stall);
        check_flag("reset redirect", 1'b0, redirect_valid);
        check_flag("reset bubble", 1'b1, mem_wb_buff.ctrl.is_bubble);
        check_value("reset instr", `RV_NOP_INSTR, mem_wb_buff.instr);

        // Random stream with MIE clear so no interrupt is taken
        for (int i = 0; i < NUM_RANDOM; i++) begin
            cls = rand_bits(3);
            cls = (cls == 0) ? 0 : ((cls == 1) ? 1 : ((cls < 4) ? 2 : ((cls < 6) ? 3 :
                  ((cls == 6) ? 4 : 5))));
            if (rand_bits(3) == 0) begin
                addr = `MTIMECMP_ADDR;
            end else begin
                // Upper alias bit checks the index wrap
                addr = (rand_bits(5) << 2) | (rand_bits(1) != 0 ? 32'h400 : 32'h0);
            end
            id = (rand_bits(2) == 1) ? `CSR_MTVEC : ((rand_bits(1) != 0) ? `CSR_MEPC : `CSR_MIE);
            execute(make_instr(cls, addr, rand_bits(32), id), 1'b0, "random");
        end

        // Timer interrupt entry
        execute(make_instr(3, `MTIMECMP_ADDR, 32'hFFFF_FFFF, '0), 1'b0, "cmp high");
        execute(make_instr(4, '0, 32'h0000_0080, `CSR_MIE), 1'b0, "enable mtie");
        execute(make_instr(4, '0, 32'h0000_0008, `CSR_MSTATUS), 1'b0, "enable mie");
        execute(make_instr(3, `MTIMECMP_ADDR, 32'h0, '0), 1'b0, "cmp low");
        execute(make_instr(3, 32'h10, 32'hDEAD_BEEF, '0), 1'b1, "irq store");
        read_csr(`CSR_MEPC, "irq mepc");
        read_csr(`CSR_MSTATUS, "irq mstatus");
        read_csr(`CSR_MCAUSE, "irq mcause");
        execute(make_instr(2, 32'h10, '0, '0), 1'b0, "irq store dropped");
        execute(make_instr(3, `MTIMECMP_ADDR, 32'hFFFF_FFFF, '0), 1'b0, "cmp restore");

        // mret back to the saved pc
        execute(make_instr(5, '0, '0, '0), 1'b0, "mret");
        read_csr(`CSR_MSTATUS, "mret mstatus");
        execute(make_instr(4, '0, 32'h0, `CSR_MSTATUS), 1'b0, "disable mie");

        @(posedge clk);
        csr_read_id <= `CSR_MINSTRET;
        @(negedge clk);
        check_value("minstret", m_retired, csr_read_value);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+common
common/rv32_types.sv
mem_stage/rv32_mem_stage.sv
mem_stage/rv32_wb_data_master.sv
logic/rv32_csr_file.sv
logic/rv32_mtimer.sv
logic/rv32_wb_decode.sv
logic/rv32_data_ram.sv
logic/rv32_backend_top.sv
verification/rv32_backend_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f vlog.f --top-module rv32_backend_tb -o rv32_backend_sim
	@out="$$(./obj_dir/rv32_backend_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
